// ==== vlog.f ====
+incdir+source
source/mm_pkg.sv
source/mm_wb_regs.sv
source/mm_ca_issue.sv
source/mm_burst_device.sv
source/mm_rd_capture.sv
source/mm_top.sv
tests/mm_sva.sv
tests/mm_tb.sv

// ==== tests/mm_tb.sv ====
`timescale 1ns/100ps
`include "mm_cfg.svh"

module mm_tb import mm_pkg::*; ();

    // 40 bursts of at most 60 cycles each
    localparam int MAX_CYCLES = 40 * 60;

    logic                 CK_C_A = 1'b0;
    logic                 reset;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [`MM_WB_AW-1:0] wb_adr;
    logic [`MM_WB_DW-1:0] wb_dat_w;
    logic [`MM_WB_DW-1:0] wb_dat_r;
    logic                 wb_ack;

    int                   cycles;
    int                   rd_count;
    logic [31:0]          rng;
    logic [7:0]           exp_wr_total;
    logic [`MM_DQ_W-1:0]  mon_sum;
    logic [`MM_DQ_W-1:0]  sum_q[$];

    mm_top dut_i (.*);

    always #4 CK_C_A = ~CK_C_A;

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    always @(posedge CK_C_A) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout, run still going after %0d cycles", cycles);
            abort_run();
        end
    end

    // Protocol assertions bound into the DUT
    always @(posedge CK_C_A) begin
        if (dut_i.sva_i.fail_cnt != 0) begin
            $display("A bound protocol assertion on the DUT failed");
            abort_run();
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Host pattern from seed, device pattern from 0, byte pairs rise by 2
    function automatic void ref_burst(input logic ff, input logic [7:0] seed,
                                      output logic [`MM_DQ_W-1:0] sum, output int mism);
        logic [7:0] host_lo;
        logic [7:0] dev_lo;
        sum  = '0;
        mism = 0;
        for (int i = 0; i < `MM_BURST_LEN; i++) begin
            dev_lo  = 8'(2 * i);
            host_lo = seed + 8'(2 * i);
            sum     = sum + (ff ? 16'hFFFF : {dev_lo + 8'd1, dev_lo});
            if ({host_lo + 8'd1, host_lo} != {dev_lo + 8'd1, dev_lo}) begin
                mism++;
            end
        end
    endfunction

    function automatic logic [`MM_WB_DW-1:0] status_word();
        return {8'h00, 8'h00, exp_wr_total, 7'h00, 1'b0};
    endfunction

    task automatic check_reg(input string name, input logic [`MM_WB_DW-1:0] exp,
                             input logic [`MM_WB_DW-1:0] act);
        if (act !== exp) begin
            $display("Error: %s expected %08h actual %08h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_view(input string name, input logic use_cmd,
                              input reg_word_u exp, input reg_word_u act);
        logic [13:0] exp_f;
        logic [13:0] act_f;
        if (use_cmd) begin
            exp_f = {exp.cmd.seed, exp.cmd.opcode};
            act_f = {act.cmd.seed, act.cmd.opcode};
        end else begin
            exp_f = {exp.ctrl.pattern_ff, exp.ctrl.read_latency};
            act_f = {act.ctrl.pattern_ff, act.ctrl.read_latency};
        end
        if (act_f !== exp_f) begin
            $display("Error: %s expected %04h actual %04h", name, exp_f, act_f);
            abort_run();
        end
    endtask

    // Each completed read burst against the oldest expected sum
    always @(posedge CK_C_A) begin
        if (!reset && dut_i.rd_done) begin
            if (sum_q.size() == 0) begin
                $display("A read burst completed with no read command outstanding");
                abort_run();
            end else begin
                mon_sum = sum_q.pop_front();
                check_reg("burst sum", 32'(mon_sum), 32'(dut_i.rd_sum));
                check_reg("burst read errors", 32'd0, 32'(dut_i.rd_err));
                rd_count = rd_count + 1;
            end
        end
    end

    task automatic wb_write(input logic [`MM_WB_AW-1:0] adr, input logic [`MM_WB_DW-1:0] data);
        @(posedge CK_C_A);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        @(posedge CK_C_A);
        while (!wb_ack) begin
            @(posedge CK_C_A);
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input logic [`MM_WB_AW-1:0] adr, output logic [`MM_WB_DW-1:0] data);
        @(posedge CK_C_A);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        @(posedge CK_C_A);
        while (!wb_ack) begin
            @(posedge CK_C_A);
        end
        data = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic wait_idle();
        logic [`MM_WB_DW-1:0] st;
        do begin
            wb_read(`MM_ADDR_STATUS, st);
        end while (st[0]);
    endtask

    task automatic set_ctrl(input logic [`MM_LAT_W-1:0] lat, input logic ff);
        reg_word_u w;
        reg_word_u rb;
        w = '0;
        w.ctrl.read_latency = lat;
        w.ctrl.pattern_ff   = ff;
        wb_write(`MM_ADDR_CTRL, w);
        wb_read(`MM_ADDR_CTRL, rb);
        check_view("ctrl readback", 1'b0, w, rb);
    endtask

    task automatic run_cmd(input ca_op_t op, input logic [7:0] seed);
        reg_word_u w;
        reg_word_u rb;
        w = '0;
        w.cmd.opcode = op;
        w.cmd.seed   = seed;
        wb_write(`MM_ADDR_CMD, w);
        wb_read(`MM_ADDR_CMD, rb);
        check_view("cmd readback", 1'b1, w, rb);
        wait_idle();
    endtask

    task automatic run_read(input string name, input logic ff);
        logic [`MM_DQ_W-1:0]  sum;
        int                   mism;
        logic [`MM_WB_DW-1:0] rb;
        ref_burst(ff, 8'h00, sum, mism);
        sum_q.push_back(sum);
        run_cmd(CA_READ, 8'h00);
        wb_read(`MM_ADDR_RDSUM, rb);
        check_reg(name, 32'(sum), rb);
        wb_read(`MM_ADDR_STATUS, rb);
        check_reg("status after read", status_word(), rb);
    endtask

    task automatic run_write(input string name, input logic [7:0] seed);
        logic [`MM_DQ_W-1:0]  sum;
        int                   mism;
        int                   total;
        logic [`MM_WB_DW-1:0] rb;
        ref_burst(1'b0, seed, sum, mism);
        total        = int'(exp_wr_total) + mism;
        exp_wr_total = (total > 255) ? 8'hFF : 8'(total);
        run_cmd(CA_WRITE, seed);
        wb_read(`MM_ADDR_STATUS, rb);
        check_reg(name, status_word(), rb);
    endtask

    initial begin
        logic [`MM_WB_DW-1:0] rb;
        logic [`MM_LAT_W-1:0] lat;
        logic [7:0]           seed;
        logic [`MM_DQ_W-1:0]  sum;
        int                   mism;
        int                   done_before;
        reg_word_u            w;
        reset        = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        rng          = 32'd68;
        exp_wr_total = 8'h00;
        repeat (16) @(posedge CK_C_A);
        reset <= 1'b0;
        @(posedge CK_C_A);

        wb_read(`MM_ADDR_STATUS, rb);
        check_reg("status after reset", 32'd0, rb);

        // Incrementing reads at random latencies
        repeat (5) begin
            rng = xorshift32(rng);
            lat = `MM_LAT_W'(rng[3:0]) + `MM_LAT_W'd2;
            set_ctrl(lat, 1'b0);
            run_read("read sum", 1'b0);
        end

        set_ctrl(`MM_LAT_W'd6, 1'b1);
        run_read("ff read sum", 1'b1);
        wb_read(`MM_ADDR_RDSUM, rb);
        check_reg("ff read constant", 32'h0000_FFF0, rb);
        set_ctrl(`MM_LAT_W'd6, 1'b0);

        run_write("write seed 0", 8'h00);
        // 17 bursts of 16 mismatches push the count past 255
        repeat (17) begin
            rng  = xorshift32(rng);
            seed = rng[15:8];
            if (seed == 8'h00) begin
                seed = 8'h01;
            end
            run_write("write random seed", seed);
        end
        wb_read(`MM_ADDR_STATUS, rb);
        check_reg("write errors saturated", 32'd255, 32'(rb[15:8]));

        // Second CMD write lands while the first read is busy
        set_ctrl(`MM_LAT_W'd12, 1'b0);
        ref_burst(1'b0, 8'h00, sum, mism);
        sum_q.push_back(sum);
        sum_q.push_back(sum);
        done_before = rd_count;
        w = '0;
        w.cmd.opcode = CA_READ;
        wb_write(`MM_ADDR_CMD, w);
        wb_write(`MM_ADDR_CMD, w);
        if (rd_count != done_before + 1) begin
            $display("CMD write was acked while the previous burst was still busy");
            abort_run();
        end
        wait_idle();
        wb_read(`MM_ADDR_RDSUM, rb);
        check_reg("sum after held command", 32'(sum), rb);

        if (sum_q.size() == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("%0d read bursts never completed", sum_q.size());
            abort_run();
        end
    end

endmodule

// ==== tests/mm_sva.sv ====
`timescale 1ns/100ps

module mm_sva (
    input logic       CK_C_A,
    input logic       reset,
    input logic       cs,
    input logic       wb_ack,
    input logic       rdq_valid,
    input logic [1:0] rdqs
);

    // Number of failed assertions so far
    int fail_cnt = 0;

    // Command slot is a single cycle
    cs_single: assert property (@(posedge CK_C_A) disable iff (reset) cs |=> !cs)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("cs held high for two cycles");
        end

    ack_single: assert property (@(posedge CK_C_A) disable iff (reset) wb_ack |=> !wb_ack)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("wb_ack held high for two cycles");
        end

    // Read data only after marker 3 then 0
    rd_framed: assert property (@(posedge CK_C_A) disable iff (reset)
        $rose(rdq_valid) |-> ($past(rdqs, 1) == 2'b00) && ($past(rdqs, 2) == 2'b11))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("rdq_valid rose without a read preamble");
        end

endmodule

bind mm_top mm_sva sva_i (
    .CK_C_A    (CK_C_A),
    .reset     (reset),
    .cs        (cs),
    .wb_ack    (wb_ack),
    .rdq_valid (rdq_valid),
    .rdqs      (rdqs)
);

// ==== source/mm_top.sv ====
`timescale 1ns/100ps
`include "mm_cfg.svh"

module mm_top import mm_pkg::*; (
    input  logic                 CK_C_A,
    input  logic                 reset,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [`MM_WB_AW-1:0] wb_adr,
    input  logic [`MM_WB_DW-1:0] wb_dat_w,
    output logic [`MM_WB_DW-1:0] wb_dat_r,
    output logic                 wb_ack
);

    // Register stage to issue stage
    logic                 cmd_go;
    ca_op_t               cmd_op;
    logic [7:0]           cmd_seed;
    logic [`MM_LAT_W-1:0] read_latency;
    logic                 pattern_ff;

    // Host to device link
    logic                 cs;
    logic [`MM_CA_W-1:0]  ca;
    logic [`MM_DQ_W-1:0]  wdq;
    logic                 wdq_valid;
    logic [1:0]           wdqs;
    logic                 wr_done;

    // Device to host link and status returns
    logic [`MM_DQ_W-1:0]  rdq;
    logic                 rdq_valid;
    logic [1:0]           rdqs;
    logic                 wr_err_inc;
    logic [`MM_ERR_W-1:0] wr_err_cnt;
    logic                 rd_done;
    logic [`MM_DQ_W-1:0]  rd_sum;
    logic [`MM_ERR_W-1:0] rd_err;

    mm_wb_regs regs_i (.*);

    mm_ca_issue issue_i (.*);

    mm_burst_device device_i (.*);

    mm_rd_capture capture_i (.*);

endmodule

// ==== source/mm_rd_capture.sv ====
`timescale 1ns/100ps
`include "mm_cfg.svh"

module mm_rd_capture (
    input  logic                 CK_C_A,
    input  logic                 reset,
    input  logic [`MM_DQ_W-1:0]  rdq,
    input  logic                 rdq_valid,
    input  logic [1:0]           rdqs,
    input  logic                 pattern_ff,
    output logic                 rd_done,
    output logic [`MM_DQ_W-1:0]  rd_sum,
    output logic [`MM_ERR_W-1:0] rd_err
);

    localparam int BEAT_W = $clog2(`MM_BURST_LEN);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_PRE  = 2'd1;
    localparam logic [1:0] S_DATA = 2'd2;

    logic [1:0]           state;
    logic [BEAT_W-1:0]    beat;
    logic [7:0]           lo;
    logic [`MM_DQ_W-1:0]  expected;
    logic [`MM_DQ_W-1:0]  sum_acc;
    logic [`MM_ERR_W-1:0] err_acc;
    logic                 take;
    logic                 take_last;
    logic                 beat_bad;

    assign expected  = pattern_ff ? '1 : {lo + 8'd1, lo};
    // Beats outside a framed burst are ignored
    assign take      = (state == S_DATA) && rdq_valid;
    assign take_last = take && (beat == BEAT_W'(`MM_BURST_LEN - 1));
    assign beat_bad  = (rdq != expected);

    always_ff @(posedge CK_C_A) begin
        if (reset) begin
            state   <= S_IDLE;
            beat    <= '0;
            rd_done <= 1'b0;
        end else begin
            rd_done <= take_last;
            case (state)
                S_IDLE: begin
                    if (rdqs == 2'b11) begin
                        state <= S_PRE;
                    end
                end
                S_PRE: begin
                    // Second preamble cycle
                    if (rdqs == 2'b00) begin
                        state <= S_DATA;
                        beat  <= '0;
                    end else if (rdqs != 2'b11) begin
                        state <= S_IDLE;
                    end
                end
                S_DATA: begin
                    if (rdq_valid) begin
                        beat <= beat + 1'b1;
                        if (take_last) begin
                            state <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge CK_C_A) begin
        if (state == S_PRE) begin
            lo      <= 8'h00;
            sum_acc <= '0;
            err_acc <= '0;
        end else if (take) begin
            lo      <= lo + 8'd2;
            sum_acc <= sum_acc + rdq;
            err_acc <= err_acc + `MM_ERR_W'(beat_bad);
        end
        // Sum wraps at 16 bits
        if (take_last) begin
            rd_sum <= sum_acc + rdq;
            rd_err <= err_acc + `MM_ERR_W'(beat_bad);
        end
    end

endmodule

// ==== source/mm_burst_device.sv ====
`timescale 1ns/100ps
`include "mm_cfg.svh"

module mm_burst_device import mm_pkg::*; (
    input  logic                 CK_C_A,
    input  logic                 reset,
    input  logic                 cs,
    input  logic [`MM_CA_W-1:0]  ca,
    input  logic [`MM_LAT_W-1:0] read_latency,
    input  logic                 pattern_ff,
    input  logic [`MM_DQ_W-1:0]  wdq,
    input  logic                 wdq_valid,
    input  logic [1:0]           wdqs,
    output logic [`MM_DQ_W-1:0]  rdq,
    output logic                 rdq_valid,
    output logic [1:0]           rdqs,
    output logic                 wr_err_inc,
    output logic [`MM_ERR_W-1:0] wr_err_cnt
);

    localparam int BEAT_W = $clog2(`MM_BURST_LEN);

    localparam logic [2:0] S_IDLE      = 3'd0;
    localparam logic [2:0] S_RD_WAIT   = 3'd1;
    localparam logic [2:0] S_RD_PRE_HI = 3'd2;
    localparam logic [2:0] S_RD_PRE_LO = 3'd3;
    localparam logic [2:0] S_RD_DATA   = 3'd4;
    localparam logic [2:0] S_WR_WAIT   = 3'd5;
    localparam logic [2:0] S_WR_PRE    = 3'd6;
    localparam logic [2:0] S_WR_DATA   = 3'd7;

    logic [2:0]           state;
    logic [`MM_LAT_W-1:0] lat_cnt;
    logic [BEAT_W-1:0]    beat;
    logic [7:0]           lo;
    logic [`MM_DQ_W-1:0]  pattern;
    logic [`MM_ERR_W-1:0] err_acc;
    logic                 beat_bad;
    logic                 last_beat;
    logic                 wr_last;

    // Same incrementing pattern in both directions, always from 0 here
    assign pattern   = {lo + 8'd1, lo};
    assign rdq       = pattern_ff ? '1 : pattern;
    assign rdq_valid = (state == S_RD_DATA);
    assign rdqs      = (state == S_RD_PRE_HI) ? 2'b11 : 2'b00;
    assign beat_bad  = wdq_valid && (wdq != pattern);
    assign last_beat = (beat == BEAT_W'(`MM_BURST_LEN - 1));
    assign wr_last   = (state == S_WR_DATA) && wdq_valid && last_beat;

    always_ff @(posedge CK_C_A) begin
        if (reset) begin
            state      <= S_IDLE;
            lat_cnt    <= '0;
            beat       <= '0;
            lo         <= 8'h00;
            err_acc    <= '0;
            wr_err_inc <= 1'b0;
        end else begin
            wr_err_inc <= wr_last;
            case (state)
                S_IDLE: begin
                    if (cs && (ca == CA_READ)) begin
                        // Latency 0 or 1 both give preamble right after CS
                        if (read_latency <= `MM_LAT_W'd1) begin
                            state <= S_RD_PRE_HI;
                        end else begin
                            state   <= S_RD_WAIT;
                            lat_cnt <= read_latency - 1'b1;
                        end
                    end else if (cs && (ca == CA_WRITE)) begin
                        state <= S_WR_WAIT;
                    end
                end
                S_RD_WAIT: begin
                    if (lat_cnt == `MM_LAT_W'd1) begin
                        state <= S_RD_PRE_HI;
                    end
                    lat_cnt <= lat_cnt - 1'b1;
                end
                S_RD_PRE_HI: state <= S_RD_PRE_LO;
                S_RD_PRE_LO: begin
                    state <= S_RD_DATA;
                    beat  <= '0;
                    lo    <= 8'h00;
                end
                S_RD_DATA: begin
                    beat <= beat + 1'b1;
                    lo   <= lo + 8'd2;
                    if (last_beat) begin
                        state <= S_IDLE;
                    end
                end
                S_WR_WAIT: begin
                    if (wdqs == 2'b11) begin
                        state <= S_WR_PRE;
                    end
                end
                S_WR_PRE: begin
                    // Marker must drop to 0 before the first beat
                    if (wdqs == 2'b00) begin
                        state   <= S_WR_DATA;
                        beat    <= '0;
                        lo      <= 8'h00;
                        err_acc <= '0;
                    end else if (wdqs != 2'b11) begin
                        state <= S_WR_WAIT;
                    end
                end
                S_WR_DATA: begin
                    if (wdq_valid) begin
                        beat    <= beat + 1'b1;
                        lo      <= lo + 8'd2;
                        err_acc <= err_acc + `MM_ERR_W'(beat_bad);
                        if (last_beat) begin
                            state <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Mismatch total for the burst, valid with wr_err_inc
    always_ff @(posedge CK_C_A) begin
        if (wr_last) begin
            wr_err_cnt <= err_acc + `MM_ERR_W'(beat_bad);
        end
    end

endmodule

// ==== source/mm_ca_issue.sv ====
`timescale 1ns/100ps
`include "mm_cfg.svh"

module mm_ca_issue import mm_pkg::*; (
    input  logic                CK_C_A,
    input  logic                reset,
    input  logic                cmd_go,
    input  ca_op_t              cmd_op,
    input  logic [7:0]          cmd_seed,
    output logic                cs,
    output logic [`MM_CA_W-1:0] ca,
    output logic [`MM_DQ_W-1:0] wdq,
    output logic                wdq_valid,
    output logic [1:0]          wdqs,
    output logic                wr_done
);

    localparam int BEAT_W = $clog2(`MM_BURST_LEN);
    localparam int WL_W   = $clog2(`MM_WL + 1);

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_WAIT   = 3'd1;
    localparam logic [2:0] S_PRE_HI = 3'd2;
    localparam logic [2:0] S_PRE_LO = 3'd3;
    localparam logic [2:0] S_DATA   = 3'd4;

    logic [2:0]        state;
    logic [WL_W-1:0]   wl_cnt;
    logic [BEAT_W-1:0] beat;
    logic [7:0]        seed_q;
    logic [7:0]        lo;

    // Byte pair, upper byte one above lower
    assign wdq       = {lo + 8'd1, lo};
    assign wdq_valid = (state == S_DATA);
    assign wdqs      = (state == S_PRE_HI) ? 2'b11 : 2'b00;
    assign wr_done   = wdq_valid && (beat == BEAT_W'(`MM_BURST_LEN - 1));

    always_ff @(posedge CK_C_A) begin
        if (reset) begin
            state  <= S_IDLE;
            cs     <= 1'b0;
            ca     <= CA_NOP;
            wl_cnt <= '0;
            beat   <= '0;
        end else begin
            // One-cycle command slot
            cs <= cmd_go;
            ca <= cmd_go ? cmd_op : CA_NOP;
            case (state)
                S_IDLE: begin
                    if (cmd_go && (cmd_op == CA_WRITE)) begin
                        state  <= S_WAIT;
                        wl_cnt <= WL_W'(`MM_WL);
                    end
                end
                S_WAIT: begin
                    // Count starts in the CS cycle
                    if (wl_cnt == WL_W'(1)) begin
                        state <= S_PRE_HI;
                    end
                    wl_cnt <= wl_cnt - 1'b1;
                end
                S_PRE_HI: state <= S_PRE_LO;
                S_PRE_LO: begin
                    state <= S_DATA;
                    beat  <= '0;
                end
                S_DATA: begin
                    beat <= beat + 1'b1;
                    if (beat == BEAT_W'(`MM_BURST_LEN - 1)) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge CK_C_A) begin
        if (cmd_go) begin
            seed_q <= cmd_seed;
        end
        if (state == S_PRE_LO) begin
            lo <= seed_q;
        end else if (state == S_DATA) begin
            lo <= lo + 8'd2;
        end
    end

endmodule

// ==== source/mm_wb_regs.sv ====
`timescale 1ns/100ps
`include "mm_cfg.svh"

module mm_wb_regs import mm_pkg::*; (
    input  logic                 CK_C_A,
    input  logic                 reset,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [`MM_WB_AW-1:0] wb_adr,
    input  logic [`MM_WB_DW-1:0] wb_dat_w,
    input  logic                 rd_done,
    input  logic [`MM_DQ_W-1:0]  rd_sum,
    input  logic [`MM_ERR_W-1:0] rd_err,
    input  logic                 wr_done,
    input  logic                 wr_err_inc,
    input  logic [`MM_ERR_W-1:0] wr_err_cnt,
    output logic [`MM_WB_DW-1:0] wb_dat_r,
    output logic                 wb_ack,
    output logic                 cmd_go,
    output ca_op_t               cmd_op,
    output logic [7:0]           cmd_seed,
    output logic [`MM_LAT_W-1:0] read_latency,
    output logic                 pattern_ff
);

    reg_word_u          wr_word;
    reg_word_u          rd_view;
    logic               busy;
    logic               cmd_hit;
    logic               cmd_hold;
    logic               cmd_valid;
    logic               accept;
    logic [7:0]         wr_err_total;
    logic [7:0]         rd_err_total;
    logic [`MM_DQ_W-1:0] rdsum_q;

    // Error totals stick at 255
    function automatic logic [7:0] sat_add(input logic [7:0] base,
                                           input logic [`MM_ERR_W-1:0] inc);
        logic [8:0] sum;
        sum = {1'b0, base} + 9'(inc);
        return sum[8] ? 8'hFF : sum[7:0];
    endfunction

    assign wr_word   = wb_dat_w;
    assign cmd_hit   = wb_we && (wb_adr == `MM_ADDR_CMD);
    // A new command waits for the burst in flight
    assign cmd_hold  = cmd_hit && busy;
    assign accept    = wb_cyc && wb_stb && !wb_ack && !cmd_hold;
    assign cmd_valid = (wr_word.cmd.opcode == CA_READ) || (wr_word.cmd.opcode == CA_WRITE);

    always_comb begin
        rd_view = '0;
        case (wb_adr)
            `MM_ADDR_CTRL: begin
                rd_view.ctrl.read_latency = read_latency;
                rd_view.ctrl.pattern_ff   = pattern_ff;
            end
            `MM_ADDR_CMD: begin
                rd_view.cmd.opcode = cmd_op;
                rd_view.cmd.seed   = cmd_seed;
            end
            `MM_ADDR_STATUS: rd_view = {8'h00, rd_err_total, wr_err_total, 7'h00, busy};
            default:         rd_view = {16'h0000, rdsum_q};
        endcase
    end

    always_ff @(posedge CK_C_A) begin
        if (reset) begin
            wb_ack       <= 1'b0;
            cmd_go       <= 1'b0;
            cmd_op       <= CA_NOP;
            cmd_seed     <= 8'h00;
            read_latency <= `MM_LAT_W'd8;
            pattern_ff   <= 1'b0;
            busy         <= 1'b0;
            wr_err_total <= 8'h00;
            rd_err_total <= 8'h00;
            rdsum_q      <= '0;
        end else begin
            wb_ack <= accept;
            // Launch in the ack cycle, unknown opcodes are acked and dropped
            cmd_go <= accept && cmd_hit && cmd_valid;
            if (accept && wb_we && (wb_adr == `MM_ADDR_CTRL)) begin
                read_latency <= wr_word.ctrl.read_latency;
                pattern_ff   <= wr_word.ctrl.pattern_ff;
            end
            if (accept && cmd_hit && cmd_valid) begin
                cmd_op   <= wr_word.cmd.opcode;
                cmd_seed <= wr_word.cmd.seed;
            end
            if (cmd_go) begin
                busy <= 1'b1;
            end else if (rd_done || wr_done) begin
                busy <= 1'b0;
            end
            if (wr_err_inc) begin
                wr_err_total <= sat_add(wr_err_total, wr_err_cnt);
            end
            if (rd_done) begin
                rd_err_total <= sat_add(rd_err_total, rd_err);
                rdsum_q      <= rd_sum;
            end
        end
    end

    // Read data is captured with the ack
    always_ff @(posedge CK_C_A) begin
        if (accept) begin
            wb_dat_r <= rd_view;
        end
    end

endmodule

// ==== source/mm_pkg.sv ====
`include "mm_cfg.svh"

package mm_pkg;

    // Command codes carried on CA with CS high
    typedef enum logic [`MM_CA_W-1:0] {
        CA_NOP   = `MM_CA_W'd0,
        CA_READ  = `MM_CA_W'd2,
        CA_WRITE = `MM_CA_W'd4
    } ca_op_t;

    // One written Wishbone word, read two ways depending on address
    typedef union packed {
        // CTRL address
        struct packed {
            logic [`MM_WB_DW-`MM_LAT_W-2:0] spare;
            logic                           pattern_ff;
            logic [`MM_LAT_W-1:0]           read_latency;
        } ctrl;
        // CMD address
        struct packed {
            logic [`MM_WB_DW-`MM_CA_W-9:0]  spare;
            logic [7:0]                     seed;
            ca_op_t                         opcode;
        } cmd;
    } reg_word_u;

endpackage

// ==== source/mm_cfg.svh ====
`ifndef MM_CFG_SVH
`define MM_CFG_SVH

// Link widths
`define MM_DQ_W       16
`define MM_CA_W       6

// Burst shape
`define MM_BURST_LEN  16
// Write latency, CS cycle to first write preamble cycle
`define MM_WL         4

// Width of a per-burst mismatch count, 0 to 16
`define MM_ERR_W      5
// Width of the programmable read latency
`define MM_LAT_W      5

// Wishbone port sizes
`define MM_WB_AW      2
`define MM_WB_DW      32

// Register word addresses
`define MM_ADDR_CTRL    2'd0
`define MM_ADDR_CMD     2'd1
`define MM_ADDR_STATUS  2'd2
`define MM_ADDR_RDSUM   2'd3

`endif
